/* src/rv_macros.svh */
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// core sizes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define RV_XLEN 32 // data and address width.
`define RV_REG_AW 5 // 32 architectural registers.

`define RV_IMEM_DEPTH 64 // instruction words.
`define RV_DMEM_DEPTH 64 // data words.

`define RV_RESET_PC 32'h0000_0000

`endif

/* src/rv_pkg.sv */
package rv_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011, // add sub and or xor slt.
        OPC_OP_IMM = 7'b0010011, // addi and friends.
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_SYSTEM = 7'b1110011 // ecall halts.
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B // link address for jal.
    } alu_op_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pipeline control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic {
        FWD_REG, // value read in decode.
        FWD_MW // result of memory/writeback.
    } fwd_sel_e;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        HALT
    } run_state_e;

endpackage

/* src/rv_pipe_if.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

interface dx_if;
    import rv_pkg::*;

    logic valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_REG_AW-1:0] rs1, rs2, rd;
    logic [`RV_XLEN-1:0] rs1_val, rs2_val, imm;
    alu_op_e alu_op;
    logic alu_src_imm, reg_write, mem_read, mem_write;
    logic branch, branch_ne, jump, halt;

    modport dec (output valid, pc, rs1, rs2, rs1_val, rs2_val, rd, imm, alu_op,
                 alu_src_imm, reg_write, mem_read, mem_write, branch, branch_ne, jump, halt);
    modport exe (input valid, pc, rs1_val, rs2_val, rd, imm, alu_op,
                 alu_src_imm, reg_write, mem_read, mem_write, branch, branch_ne, jump, halt);
    modport haz (input rs1, rs2);
endinterface

interface xm_if;
    logic valid;
    logic [`RV_XLEN-1:0] result; // alu result or link address.
    logic [`RV_XLEN-1:0] store_data;
    logic [`RV_REG_AW-1:0] rd;
    logic reg_write, mem_read, mem_write, halt;

    modport exe (output valid, result, store_data, rd, reg_write, mem_read, mem_write, halt);
    modport mw (input valid, result, store_data, rd, reg_write, mem_read, mem_write, halt);
    modport haz (input valid, rd, reg_write);
endinterface

/* src/run_ctrl.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module run_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                trigger,
    input  logic                wb_retire,
    input  logic                wb_halt,
    output logic                run,
    output rv_pkg::run_state_e  run_state,
    output logic [`RV_XLEN-1:0] retired
);
    import rv_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_state <= IDLE;
        end else begin
            case (run_state)
                IDLE:    if (trigger) run_state <= RUN;
                RUN:     if (wb_halt) run_state <= HALT;
                HALT:    run_state <= HALT; // only reset leaves.
                default: run_state <= IDLE;
            endcase
        end
    end

    assign run = (run_state == RUN);

    // ecall itself is not counted.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            retired <= '0;
        end else if (run && wb_retire) begin
            retired <= retired + 1'b1;
        end
    end

endmodule

/* src/fetch_stage.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module fetch_stage (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                run,
    input  logic                                flush,
    input  logic [`RV_XLEN-1:0]                 target,
    input  logic                                prog_we,
    input  logic [$clog2(`RV_IMEM_DEPTH)-1:0]   prog_addr,
    input  logic [`RV_XLEN-1:0]                 prog_data,
    output logic                                fd_valid,
    output logic [`RV_XLEN-1:0]                 fd_pc,
    output logic [`RV_XLEN-1:0]                 fd_instr
);
    localparam int IMEM_AW = $clog2(`RV_IMEM_DEPTH);

    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] imem [`RV_IMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (prog_we) imem[prog_addr] <= prog_data; // loaded while idle.
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= `RV_RESET_PC;
            fd_valid <= 1'b0;
        end else if (run) begin
            pc       <= flush ? target : pc + 32'd4;
            fd_valid <= !flush; // squash the wrong-path fetch.
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            fd_pc    <= pc;
            fd_instr <= imem[pc[IMEM_AW+1:2]]; // word index wraps.
        end
    end

endmodule

/* src/decode_stage.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  run,
    input  logic                  flush,
    input  logic                  fd_valid,
    input  logic [`RV_XLEN-1:0]   fd_pc,
    input  logic [`RV_XLEN-1:0]   fd_instr,
    input  logic                  wb_we,
    input  logic [`RV_REG_AW-1:0] wb_rd,
    input  logic [`RV_XLEN-1:0]   wb_data,
    dx_if.dec                     dx,
    output logic [`RV_XLEN-1:0]   a0
);
    import rv_pkg::*;

    opcode_e opc;
    logic [2:0] funct3;
    logic [`RV_REG_AW-1:0] rs1, rs2;
    logic [`RV_XLEN-1:0] imm_i, imm_s, imm_b, imm_j, imm;
    logic [`RV_XLEN-1:0] rs1_val, rs2_val;
    logic [`RV_XLEN-1:0] regs [2**`RV_REG_AW];
    alu_op_e alu_op;
    logic alu_src_imm, reg_write, mem_read, mem_write, branch, jump, halt;

    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field extraction and control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign opc    = opcode_e'(fd_instr[6:0]);
    assign funct3 = fd_instr[14:12];
    assign rs1    = fd_instr[19:15];
    assign rs2    = fd_instr[24:20];

    assign imm_i = {{20{fd_instr[31]}}, fd_instr[31:20]};
    assign imm_s = {{20{fd_instr[31]}}, fd_instr[31:25], fd_instr[11:7]};
    assign imm_b = {{19{fd_instr[31]}}, fd_instr[31], fd_instr[7],
                    fd_instr[30:25], fd_instr[11:8], 1'b0};
    assign imm_j = {{11{fd_instr[31]}}, fd_instr[31], fd_instr[19:12],
                    fd_instr[20], fd_instr[30:21], 1'b0};

    always_comb begin
        alu_op      = ALU_ADD;
        imm         = imm_i;
        alu_src_imm = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        halt        = 1'b0;
        case (opc)
            OPC_OP: begin
                reg_write = 1'b1;
                alu_op    = alu_from_funct(funct3, fd_instr[30]);
            end
            OPC_OP_IMM: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                alu_op      = alu_from_funct(funct3, 1'b0); // no subi.
            end
            OPC_LOAD: begin
                reg_write   = 1'b1;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
            end
            OPC_STORE: begin
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
                imm         = imm_s;
            end
            OPC_BRANCH: begin
                branch = 1'b1;
                imm    = imm_b;
            end
            OPC_JAL: begin
                jump      = 1'b1;
                reg_write = 1'b1;
                alu_op    = ALU_PASS_B;
                imm       = imm_j;
            end
            OPC_SYSTEM: halt = 1'b1;
            default: ; // unknown opcodes retire as nops.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 2**`RV_REG_AW; i++) begin
                regs[i] <= '0;
            end
        end else if (run && wb_we) begin
            regs[wb_rd] <= wb_data; // wb_we is never set for x0.
        end
    end

    // same-cycle writeback is passed straight through.
    assign rs1_val = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    assign a0 = regs[10];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dx.valid <= 1'b0;
        end else if (run) begin
            dx.valid <= fd_valid && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            dx.pc          <= fd_pc;
            dx.rs1         <= rs1;
            dx.rs2         <= rs2;
            dx.rs1_val     <= rs1_val;
            dx.rs2_val     <= rs2_val;
            dx.rd          <= fd_instr[11:7];
            dx.imm         <= imm;
            dx.alu_op      <= alu_op;
            dx.alu_src_imm <= alu_src_imm;
            dx.reg_write   <= reg_write;
            dx.mem_read    <= mem_read;
            dx.mem_write   <= mem_write;
            dx.branch      <= branch;
            dx.branch_ne   <= funct3[0]; // bne has funct3 001.
            dx.jump        <= jump;
            dx.halt        <= halt;
        end
    end

endmodule

/* src/execute_stage.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module execute_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                run,
    input  rv_pkg::fwd_sel_e    fwd_a,
    input  rv_pkg::fwd_sel_e    fwd_b,
    input  logic [`RV_XLEN-1:0] wb_data,
    dx_if.exe                   dx,
    xm_if.exe                   xm,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] target
);
    import rv_pkg::*;

    logic [`RV_XLEN-1:0] a, b, op_b, link, alu_y;
    logic taken;

    assign a    = (fwd_a == FWD_MW) ? wb_data : dx.rs1_val;
    assign b    = (fwd_b == FWD_MW) ? wb_data : dx.rs2_val;
    assign link = dx.pc + 32'd4;
    assign op_b = dx.jump ? link : (dx.alu_src_imm ? dx.imm : b);

    always_comb begin
        case (dx.alu_op)
            ALU_ADD: alu_y = a + op_b;
            ALU_SUB: alu_y = a - op_b;
            ALU_AND: alu_y = a & op_b;
            ALU_OR:  alu_y = a | op_b;
            ALU_XOR: alu_y = a ^ op_b;
            ALU_SLT: alu_y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(op_b)};
            default: alu_y = op_b;
        endcase
    end

    // beq and bne share one comparator.
    assign taken    = dx.branch && ((a == b) != dx.branch_ne);
    assign redirect = dx.valid && (taken || dx.jump);
    assign target   = dx.pc + dx.imm;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            xm.valid <= 1'b0;
        end else if (run) begin
            xm.valid <= dx.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (run) begin
            xm.result     <= alu_y;
            xm.store_data <= b;
            xm.rd         <= dx.rd;
            xm.reg_write  <= dx.reg_write;
            xm.mem_read   <= dx.mem_read;
            xm.mem_write  <= dx.mem_write;
            xm.halt       <= dx.halt;
        end
    end

endmodule

/* src/mem_wb_stage.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module mem_wb_stage (
    input  logic                  clk,
    input  logic                  run,
    xm_if.mw                      xm,
    output logic                  wb_we,
    output logic [`RV_REG_AW-1:0] wb_rd,
    output logic [`RV_XLEN-1:0]   wb_data,
    output logic                  wb_retire,
    output logic                  wb_halt
);
    localparam int DMEM_AW = $clog2(`RV_DMEM_DEPTH);

    logic [`RV_XLEN-1:0] dmem [`RV_DMEM_DEPTH];
    logic [DMEM_AW-1:0] daddr;

    assign daddr = xm.result[DMEM_AW+1:2]; // word address, wraps.

    always_ff @(posedge clk) begin
        if (run && xm.valid && xm.mem_write) begin
            dmem[daddr] <= xm.store_data;
        end
    end

    // async read lets a load forward like an alu result.
    assign wb_data = xm.mem_read ? dmem[daddr] : xm.result;
    assign wb_we   = xm.valid && xm.reg_write && (xm.rd != '0);
    assign wb_rd   = xm.rd;

    assign wb_retire = xm.valid && !xm.halt;
    assign wb_halt   = xm.valid && xm.halt;

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module hazard_unit (
    dx_if.haz                dx,
    xm_if.haz                xm,
    input  logic             redirect,
    output rv_pkg::fwd_sel_e fwd_a,
    output rv_pkg::fwd_sel_e fwd_b,
    output logic             flush
);
    import rv_pkg::*;

    logic mw_writes;

    assign mw_writes = xm.valid && xm.reg_write;

    // only one producer stage ahead of execute, older values come from the register file.
    always_comb begin
        fwd_a = FWD_REG;
        fwd_b = FWD_REG;
        if (mw_writes && dx.rs1 != '0 && dx.rs1 == xm.rd) fwd_a = FWD_MW;
        if (mw_writes && dx.rs2 != '0 && dx.rs2 == xm.rd) fwd_b = FWD_MW;
    end

    assign flush = redirect; // kills fetch/decode and decode/execute.

endmodule

/* src/rv_pipe_top.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_pipe_top (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              trigger,
    input  logic                              prog_we,
    input  logic [$clog2(`RV_IMEM_DEPTH)-1:0] prog_addr,
    input  logic [`RV_XLEN-1:0]               prog_data,
    output logic [`RV_XLEN-1:0]               a0,
    output rv_pkg::run_state_e                run_state,
    output logic [`RV_XLEN-1:0]               retired
);
    import rv_pkg::*;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // inter-stage signals
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic run;
    logic flush;
    logic redirect;
    logic [`RV_XLEN-1:0] target;

    logic fd_valid;
    logic [`RV_XLEN-1:0] fd_pc;
    logic [`RV_XLEN-1:0] fd_instr;

    fwd_sel_e fwd_a;
    fwd_sel_e fwd_b;

    logic wb_we;
    logic [`RV_REG_AW-1:0] wb_rd;
    logic [`RV_XLEN-1:0] wb_data;
    logic wb_retire;
    logic wb_halt;

    dx_if dx ();
    xm_if xm ();

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stages, ports connect by matching names
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    run_ctrl run_ctrl_i (.*);

    fetch_stage fetch_stage_i (.*);

    decode_stage decode_stage_i (.*);

    execute_stage execute_stage_i (.*);

    mem_wb_stage mem_wb_stage_i (.*);

    hazard_unit hazard_unit_i (.*);

endmodule

/* tb/rv_pipe_checker.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module rv_pipe_checker (
    input logic                clk,
    input logic                rst_n,
    input rv_pkg::run_state_e  run_state,
    input logic [`RV_XLEN-1:0] retired
);
    import rv_pkg::*;

    int unsigned fails = 0; // read by the testbench at the end of the run.

    idle_after_reset: assert property (@(posedge clk) !rst_n |=> run_state == IDLE)
        else begin
            $error("run_state is not IDLE after reset");
            fails++;
        end

    halt_is_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        run_state == HALT |=> run_state == HALT)
        else begin
            $error("run_state left HALT without reset");
            fails++;
        end

    retired_monotonic: assert property (@(posedge clk) disable iff (!rst_n)
        retired >= $past(retired))
        else begin
            $error("retired count decreased");
            fails++;
        end

    // the counter only moves while the core runs.
    retired_frozen: assert property (@(posedge clk) disable iff (!rst_n)
        run_state != RUN |=> $stable(retired))
        else begin
            $error("retired count changed outside RUN");
            fails++;
        end

endmodule

bind run_ctrl rv_pipe_checker rv_pipe_checker_i (
    .clk(clk),
    .rst_n(rst_n),
    .run_state(run_state),
    .retired(retired)
);

/* tb/tb_rv_pipe.sv */
`timescale 1ns/1ps
`include "rv_macros.svh"

module tb_clk_gen (
    output logic clk
);
    initial clk = 1'b0;
    always #5ns clk = ~clk; // 10 ns period.
endmodule

module tb_rv_pipe;
    import rv_pkg::*;

    localparam int IMEM_AW    = $clog2(`RV_IMEM_DEPTH);
    localparam int RST_CYCLES = 16;
    localparam int NUM_TESTS  = 5;
    localparam int DYN_TOTAL  = 12 + 10 + 10 + 10 + 3; // longest path of each program.
    localparam int WATCHDOG_CYCLES = 3 * DYN_TOTAL
        + NUM_TESTS * (40 + RST_CYCLES + `RV_IMEM_DEPTH + 8) + 30;
    localparam logic [31:0] ECALL = 32'h0000_0073;

    logic clk;
    logic rst_n;
    logic trigger;
    logic prog_we;
    logic [IMEM_AW-1:0] prog_addr;
    logic [`RV_XLEN-1:0] prog_data;
    logic [`RV_XLEN-1:0] a0;
    run_state_e run_state;
    logic [`RV_XLEN-1:0] retired;

    logic [31:0] prog [$];
    int errors = 0;
    int checks = 0;
    int tests_done = 0;
    int test_errors;
    int unsigned assert_fails;
    string test_name;

    tb_clk_gen tb_clk_gen_i (.clk(clk));

    rv_pipe_top rv_pipe_top_i (.*);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] i_type(input opcode_e opc, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] addi(input logic [4:0] rd, rs1, input logic [11:0] imm);
        return i_type(OPC_OP_IMM, 3'b000, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE}; // sw only.
    endfunction

    function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                           input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // drive and compare
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_dut();
        @(negedge clk);
        rst_n   = 1'b0;
        trigger = 1'b0;
        prog_we = 1'b0;
        repeat (RST_CYCLES) @(negedge clk);
        rst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < `RV_IMEM_DEPTH; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = IMEM_AW'(i);
            // spare words hold nops tagged with their own address.
            prog_data = (i < prog.size()) ? prog[i] : addi(5'd0, 5'd0, 12'(i));
        end
        @(negedge clk);
        prog_we = 1'b0;
        prog.delete();
    endtask

    task automatic pulse_trigger();
        @(negedge clk);
        trigger = 1'b1;
        @(negedge clk);
        trigger = 1'b0;
    endtask

    task automatic start_and_wait(input int max_dyn);
        int cycles = 0;
        pulse_trigger();
        while (run_state != HALT && cycles < 3 * max_dyn + 40) begin
            @(negedge clk);
            cycles++;
        end
        if (run_state != HALT) begin
            $display("%s: core did not halt within %0d cycles", test_name, cycles);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [`RV_XLEN-1:0] got, exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: %s %s: got %h, expected %h",
                     $time, test_name, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic check_state(input string what, input run_state_e got, exp);
        checks++;
        if (got !== exp) begin
            $display("** Error @ %0t: %s %s: got %s, expected %s",
                     $time, test_name, what, got.name(), exp.name());
            errors++;
            test_errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        reset_dut();
    endtask

    task automatic finish_test();
        tests_done++;
        $display("test %-12s %s (%0d errors)", test_name,
                 (test_errors == 0) ? "ok" : "failed", test_errors);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // directed tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic test_alu();
        logic [11:0] c1, c2;
        logic [31:0] r1, r2, r3, r4, r5, r6, r7, r8, r9;
        c1 = 12'($urandom);
        c2 = 12'($urandom);
        r1 = sext12(c1);
        r2 = sext12(c2);
        r3 = r1 + r2;
        r4 = r1 - r2;
        r5 = r1 & r2;
        r6 = r1 | r2;
        r7 = r3 ^ r4;
        r8 = ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0;
        r9 = r5 + r6;
        start_test("alu");
        prog.push_back(addi(5'd1, 5'd0, c1));
        prog.push_back(addi(5'd2, 5'd0, c2));
        prog.push_back(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2)); // add.
        prog.push_back(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2)); // sub.
        prog.push_back(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2)); // and.
        prog.push_back(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2)); // or.
        prog.push_back(r_type(7'h00, 3'b100, 5'd7, 5'd3, 5'd4)); // xor.
        prog.push_back(r_type(7'h00, 3'b010, 5'd8, 5'd1, 5'd2)); // slt.
        prog.push_back(r_type(7'h00, 3'b000, 5'd9, 5'd5, 5'd6));
        prog.push_back(r_type(7'h00, 3'b100, 5'd10, 5'd7, 5'd9));
        prog.push_back(r_type(7'h00, 3'b000, 5'd10, 5'd10, 5'd8));
        prog.push_back(ECALL);
        load_program();
        start_and_wait(12);
        check_word("a0", a0, (r7 ^ r9) + r8);
        check_word("retired", retired, 32'd11);
        finish_test();
    endtask

    task automatic test_forwarding();
        logic [11:0] k0, k1, k2;
        logic [31:0] r10, r11, r12, r13;
        k0 = 12'($urandom);
        k1 = 12'($urandom);
        k2 = 12'($urandom);
        r10 = sext12(k0) + sext12(k1);
        r11 = r10 + r10;
        r10 = r11 - r10;
        r12 = r11 ^ r10;
        r10 = r12 | r11;
        r13 = ($signed(r10) < $signed(r12)) ? 32'd1 : 32'd0;
        r10 = r13 + r10 + sext12(k2);
        start_test("forwarding");
        prog.push_back(addi(5'd10, 5'd0, k0));
        prog.push_back(addi(5'd10, 5'd10, k1));
        prog.push_back(r_type(7'h00, 3'b000, 5'd11, 5'd10, 5'd10));
        prog.push_back(r_type(7'h20, 3'b000, 5'd10, 5'd11, 5'd10));
        prog.push_back(r_type(7'h00, 3'b100, 5'd12, 5'd11, 5'd10));
        prog.push_back(r_type(7'h00, 3'b110, 5'd10, 5'd12, 5'd11));
        prog.push_back(r_type(7'h00, 3'b010, 5'd13, 5'd10, 5'd12));
        prog.push_back(r_type(7'h00, 3'b000, 5'd10, 5'd13, 5'd10));
        prog.push_back(addi(5'd10, 5'd10, k2));
        prog.push_back(ECALL);
        load_program();
        start_and_wait(10);
        check_word("a0", a0, r10);
        check_word("retired", retired, 32'd9);
        finish_test();
    endtask

    task automatic test_memory();
        logic [11:0] v1, v2;
        v1 = 12'($urandom);
        v2 = 12'($urandom);
        start_test("memory");
        prog.push_back(addi(5'd1, 5'd0, v1));
        prog.push_back(addi(5'd2, 5'd0, 12'd8));
        prog.push_back(s_type(5'd2, 5'd1, 12'd0)); // word 2.
        prog.push_back(i_type(OPC_LOAD, 3'b010, 5'd3, 5'd2, 12'd0));
        prog.push_back(addi(5'd10, 5'd3, 12'd1)); // load used right away.
        prog.push_back(addi(5'd4, 5'd0, v2));
        prog.push_back(s_type(5'd0, 5'd4, 12'd260)); // byte 260 wraps to word 1.
        prog.push_back(i_type(OPC_LOAD, 3'b010, 5'd5, 5'd0, 12'd4));
        prog.push_back(r_type(7'h00, 3'b000, 5'd10, 5'd10, 5'd5));
        prog.push_back(ECALL);
        load_program();
        start_and_wait(10);
        check_word("a0", a0, sext12(v1) + 32'd1 + sext12(v2));
        check_word("retired", retired, 32'd9);
        finish_test();
    endtask

    task automatic test_control_flow();
        start_test("control_flow");
        prog.push_back(addi(5'd10, 5'd0, 12'd5)); // pc 0.
        prog.push_back(addi(5'd1, 5'd0, 12'd5));
        prog.push_back(b_type(3'b000, 5'd10, 5'd1, 13'd12)); // pc 8, beq taken.
        prog.push_back(addi(5'd10, 5'd10, 12'd100));
        prog.push_back(addi(5'd10, 5'd10, 12'd200));
        prog.push_back(b_type(3'b001, 5'd10, 5'd1, 13'd12)); // pc 20, bne not taken.
        prog.push_back(addi(5'd10, 5'd10, 12'd1));
        prog.push_back(b_type(3'b001, 5'd10, 5'd1, 13'd12)); // pc 28, bne taken.
        prog.push_back(addi(5'd10, 5'd10, 12'd100));
        prog.push_back(addi(5'd10, 5'd10, 12'd200));
        prog.push_back(b_type(3'b000, 5'd10, 5'd1, 13'd8)); // pc 40, beq not taken.
        prog.push_back(j_type(5'd2, 21'd12)); // pc 44, jal x2 to 56.
        prog.push_back(addi(5'd10, 5'd10, 12'd100));
        prog.push_back(addi(5'd10, 5'd10, 12'd200));
        prog.push_back(r_type(7'h00, 3'b000, 5'd10, 5'd10, 5'd2)); // pc 56.
        prog.push_back(ECALL);
        load_program();
        start_and_wait(10);
        // 5 + 1 on the taken path, plus the jal link of pc 44.
        check_word("a0", a0, 32'd6 + (32'd44 + 32'd4));
        check_word("retired", retired, 32'd9);
        finish_test();
    endtask

    task automatic test_run_control();
        logic [11:0] c;
        logic [31:0] exp;
        c   = 12'($urandom);
        exp = sext12(c) + 32'd1;
        start_test("run_control");
        prog.push_back(addi(5'd10, 5'd0, c));
        prog.push_back(addi(5'd10, 5'd10, 12'd1));
        prog.push_back(ECALL);
        load_program();
        repeat (20) @(negedge clk);
        check_state("state before trigger", run_state, IDLE);
        check_word("a0 before trigger", a0, 32'd0);
        start_and_wait(3);
        check_word("a0", a0, exp);
        check_word("retired", retired, 32'd2);
        pulse_trigger(); // ignored in HALT.
        repeat (10) @(negedge clk);
        check_state("state after second trigger", run_state, HALT);
        check_word("a0 after second trigger", a0, exp);
        check_word("retired after second trigger", retired, 32'd2);
        finish_test();
    endtask

    initial begin
        rst_n     = 1'b0;
        trigger   = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        void'($urandom(32'hb1b8));
        test_alu();
        test_forwarding();
        test_memory();
        test_control_flow();
        test_run_control();
        assert_fails = rv_pipe_top_i.run_ctrl_i.rv_pipe_checker_i.fails;
        $display("summary: %0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests_done, checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * 10ns);
        $display("timeout: simulation did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* tb.f */
+incdir+src
src/rv_pkg.sv
src/rv_pipe_if.sv
src/run_ctrl.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/mem_wb_stage.sv
src/hazard_unit.sv
src/rv_pipe_top.sv
tb/rv_pipe_checker.sv
tb/tb_rv_pipe.sv

/* Bender.yml */
package:
  name: rv_pipe

sources:
  - include_dirs:
      - src
    files:
      - src/rv_pkg.sv
      - src/rv_pipe_if.sv
      - src/run_ctrl.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/mem_wb_stage.sv
      - src/hazard_unit.sv
      - src/rv_pipe_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tb/rv_pipe_checker.sv
      - tb/tb_rv_pipe.sv
